/* logic/pmu_config.svh */
// PMU configuration macros: widths, counter count and register map
`ifndef PMU_CONFIG_SVH
`define PMU_CONFIG_SVH

// --------------------------------------------------
// Datapath sizes
// --------------------------------------------------

// Register and counter width
`define PMU_REG_WIDTH 32
// Event inputs, one counter each
`define PMU_N_COUNTERS 9
// Register port address width
`define PMU_ADDR_WIDTH 4

// --------------------------------------------------
// Register map
// --------------------------------------------------

// Main configuration word
`define PMU_ADDR_CFG 0
// First counter, counters packed upwards from here
`define PMU_ADDR_CNT_BASE 1
// Overflow interrupt mask
`define PMU_ADDR_OVF_MASK 10
// Sticky overflow vector, read only
`define PMU_ADDR_OVF_VECT 11
// Counters taking part in the quota sum
`define PMU_ADDR_QUOTA_MASK 12
// Quota threshold
`define PMU_ADDR_QUOTA_LIMIT 13

// --------------------------------------------------
// Configuration word bit positions
// --------------------------------------------------

`define PMU_CFG_EN 0
`define PMU_CFG_SOFTRST 1
`define PMU_CFG_OVF_EN 2
`define PMU_CFG_OVF_SOFTRST 3
`define PMU_CFG_QUOTA_SOFTRST 4
// Low bit of the two-bit self-test field
`define PMU_CFG_SELFTEST_LSB 30

`endif

/* logic/pmu_pkg.sv */
// PMU shared types: self-test modes, decoded configuration and counter arrays
`include "pmu_config.svh"

package pmu_pkg;

    // --------------------------------------------------
    // Self-test event override
    // --------------------------------------------------

    // Encoding follows the two config bits directly
    typedef enum logic [1:0] {
        SELFTEST_OFF     = 2'b00,
        SELFTEST_ALL_ON  = 2'b01,
        SELFTEST_ALL_OFF = 2'b10,
        SELFTEST_ONE_ON  = 2'b11
    } selftest_e;

    // Decoded control bits of the config word
    typedef struct packed {
        selftest_e selftest;
        logic      quota_softrst;
        logic      ovf_softrst;
        logic      ovf_en;
        logic      softrst;
        logic      en;
    } pmu_cfg_t;

    // --------------------------------------------------
    // Counter datapath types
    // --------------------------------------------------

    // One bit per counter
    typedef logic [`PMU_N_COUNTERS-1:0] event_vec_t;

    // Single counter value
    typedef logic [`PMU_REG_WIDTH-1:0] counter_t;

    // All counters side by side, index 0 in the low bits
    typedef counter_t [`PMU_N_COUNTERS-1:0] counter_array_t;

    // Preload request from a register write
    typedef struct packed {
        logic                       valid;
        logic [`PMU_ADDR_WIDTH-1:0] idx;
        counter_t                   value;
    } cnt_load_t;

endpackage

/* logic/pmu_regbank.sv */
// PMU register bank: config, masks and limit, counter preload decode and read mux
`timescale 1ns/1ps
`include "pmu_config.svh"

module pmu_regbank (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        reg_we_i,
    input  logic [`PMU_ADDR_WIDTH-1:0]  reg_addr_i,
    input  pmu_pkg::counter_t           reg_wdata_i,
    input  pmu_pkg::counter_array_t     counts_i,
    input  pmu_pkg::event_vec_t         ovf_vect_i,
    output pmu_pkg::counter_t           reg_rdata_o,
    output pmu_pkg::pmu_cfg_t           cfg_o,
    output pmu_pkg::cnt_load_t          cnt_load_o,
    output pmu_pkg::event_vec_t         ovf_mask_o,
    output pmu_pkg::event_vec_t         quota_mask_o,
    output pmu_pkg::counter_t           quota_limit_o
);

    // Counter window bounds in address space
    localparam logic [`PMU_ADDR_WIDTH-1:0] CNT_FIRST = `PMU_ADDR_CNT_BASE;
    localparam logic [`PMU_ADDR_WIDTH-1:0] CNT_LAST  =
        `PMU_ADDR_CNT_BASE + `PMU_N_COUNTERS - 1;

    // Software-owned registers
    pmu_pkg::counter_t   cfg_q;
    pmu_pkg::event_vec_t ovf_mask_q;
    pmu_pkg::event_vec_t quota_mask_q;
    pmu_pkg::counter_t   quota_limit_q;

    // Counter window decode
    logic                       cnt_hit;
    logic [`PMU_ADDR_WIDTH-1:0] cnt_idx;

    assign cnt_hit = (reg_addr_i >= CNT_FIRST) && (reg_addr_i <= CNT_LAST);
    // Offset into the counter array
    assign cnt_idx = reg_addr_i - CNT_FIRST;

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_q         <= '0;
            ovf_mask_q    <= '0;
            quota_mask_q  <= '0;
            quota_limit_q <= '0;
        end else if (reg_we_i) begin
            // Counter and vector addresses are not stored here
            case (reg_addr_i)
                `PMU_ADDR_CFG:         cfg_q         <= reg_wdata_i;
                `PMU_ADDR_OVF_MASK:    ovf_mask_q    <= reg_wdata_i[`PMU_N_COUNTERS-1:0];
                `PMU_ADDR_QUOTA_MASK:  quota_mask_q  <= reg_wdata_i[`PMU_N_COUNTERS-1:0];
                `PMU_ADDR_QUOTA_LIMIT: quota_limit_q <= reg_wdata_i;
                default: ;
            endcase
        end
    end

    // Preload request, taken by the counters on this same edge
    always_comb begin
        cnt_load_o.valid = reg_we_i && cnt_hit;
        cnt_load_o.idx   = cnt_idx;
        cnt_load_o.value = reg_wdata_i;
    end

    // Config bits out to the monitoring blocks
    always_comb begin
        cfg_o.en            = cfg_q[`PMU_CFG_EN];
        cfg_o.softrst       = cfg_q[`PMU_CFG_SOFTRST];
        cfg_o.ovf_en        = cfg_q[`PMU_CFG_OVF_EN];
        cfg_o.ovf_softrst   = cfg_q[`PMU_CFG_OVF_SOFTRST];
        cfg_o.quota_softrst = cfg_q[`PMU_CFG_QUOTA_SOFTRST];
        cfg_o.selftest      = pmu_pkg::selftest_e'(cfg_q[`PMU_CFG_SELFTEST_LSB +: 2]);
    end

    assign ovf_mask_o    = ovf_mask_q;
    assign quota_mask_o  = quota_mask_q;
    assign quota_limit_o = quota_limit_q;

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------

    always_comb begin
        reg_rdata_o = '0;
        if (cnt_hit) begin
            reg_rdata_o = counts_i[cnt_idx];
        end else begin
            // Narrow registers are zero extended
            case (reg_addr_i)
                `PMU_ADDR_CFG:         reg_rdata_o = cfg_q;
                `PMU_ADDR_OVF_MASK:    reg_rdata_o = pmu_pkg::counter_t'(ovf_mask_q);
                `PMU_ADDR_OVF_VECT:    reg_rdata_o = pmu_pkg::counter_t'(ovf_vect_i);
                `PMU_ADDR_QUOTA_MASK:  reg_rdata_o = pmu_pkg::counter_t'(quota_mask_q);
                `PMU_ADDR_QUOTA_LIMIT: reg_rdata_o = quota_limit_q;
                // Unmapped space
                default:               reg_rdata_o = '0;
            endcase
        end
    end

endmodule

/* logic/pmu_counters.sv */
// PMU event counters with self-test override, preload, soft reset and wrap flags
`timescale 1ns/1ps
`include "pmu_config.svh"

module pmu_counters (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  pmu_pkg::event_vec_t     events_i,
    input  pmu_pkg::pmu_cfg_t       cfg_i,
    input  pmu_pkg::cnt_load_t      cnt_load_i,
    output pmu_pkg::counter_array_t counts_o,
    output pmu_pkg::event_vec_t     wrap_o
);

    // Events after the self-test override
    pmu_pkg::event_vec_t     events_eff;
    // Per-counter increment and preload selects
    pmu_pkg::event_vec_t     inc;
    pmu_pkg::event_vec_t     load_hit;
    pmu_pkg::counter_array_t counts_q;

    // --------------------------------------------------
    // Self-test override
    // --------------------------------------------------

    always_comb begin
        case (cfg_i.selftest)
            pmu_pkg::SELFTEST_OFF:     events_eff = events_i;
            pmu_pkg::SELFTEST_ALL_ON:  events_eff = '1;
            pmu_pkg::SELFTEST_ALL_OFF: events_eff = '0;
            // Only counter 0 sees activity
            pmu_pkg::SELFTEST_ONE_ON:  events_eff = pmu_pkg::event_vec_t'(1);
            default:                   events_eff = events_i;
        endcase
    end

    // --------------------------------------------------
    // Increment, preload and wrap decode
    // --------------------------------------------------

    always_comb begin
        for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
            load_hit[i] = cnt_load_i.valid && (int'(cnt_load_i.idx) == i);
            // Counting gated by enable, blocked during soft reset
            inc[i]      = cfg_i.en && !cfg_i.softrst && events_eff[i];
            // All ones plus one, unless a preload wins
            wrap_o[i]   = inc[i] && !load_hit[i] && (counts_q[i] == '1);
        end
    end

    // Soft reset over preload over increment
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            counts_q <= '0;
        end else if (cfg_i.softrst) begin
            counts_q <= '0;
        end else begin
            for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
                if (load_hit[i]) begin
                    counts_q[i] <= cnt_load_i.value;
                end else if (inc[i]) begin
                    // Rolls over to zero after all ones
                    counts_q[i] <= counts_q[i] + 1'b1;
                end
            end
        end
    end

    assign counts_o = counts_q;

endmodule

/* logic/pmu_overflow.sv */
// PMU overflow tracking: sticky per-counter wrap vector and masked interrupt
`timescale 1ns/1ps

module pmu_overflow (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  pmu_pkg::pmu_cfg_t   cfg_i,
    input  pmu_pkg::event_vec_t wrap_i,
    input  pmu_pkg::event_vec_t mask_i,
    output pmu_pkg::event_vec_t vect_o,
    output logic                intr_overflow_o
);

    // Sticky wrap record
    pmu_pkg::event_vec_t vect_q;

    // --------------------------------------------------
    // Sticky vector
    // --------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vect_q <= '0;
        end else if (cfg_i.ovf_softrst) begin
            // Whole vector cleared at once
            vect_q <= '0;
        end else if (cfg_i.ovf_en) begin
            // Wraps accumulate, never self-clear
            vect_q <= vect_q | wrap_i;
        end
    end

    assign vect_o = vect_q;

    // Any recorded wrap that software left unmasked
    assign intr_overflow_o = |(vect_q & mask_i);

endmodule

/* logic/pmu_quota.sv */
// PMU quota check: registered sum of selected counters compared to a limit
`timescale 1ns/1ps
`include "pmu_config.svh"

module pmu_quota (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  pmu_pkg::pmu_cfg_t       cfg_i,
    input  pmu_pkg::counter_array_t counts_i,
    input  pmu_pkg::event_vec_t     mask_i,
    input  pmu_pkg::counter_t       limit_i,
    output logic                    intr_quota_o
);

    // Combinational sum and its registered copy
    pmu_pkg::counter_t sum_next;
    pmu_pkg::counter_t sum_q;

    // --------------------------------------------------
    // Masked accumulation
    // --------------------------------------------------

    // Carries out of the top bit are dropped
    always_comb begin
        sum_next = '0;
        for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
            if (mask_i[i]) begin
                sum_next = sum_next + counts_i[i];
            end
        end
    end

    // One stage of delay against the counters
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sum_q <= '0;
        end else if (cfg_i.quota_softrst) begin
            // Held at zero while soft reset stays set
            sum_q <= '0;
        end else begin
            sum_q <= sum_next;
        end
    end

    // --------------------------------------------------
    // Threshold compare
    // --------------------------------------------------

    // Strictly above the limit
    assign intr_quota_o = (sum_q > limit_i);

endmodule

/* logic/pmu_top.sv */
// PMU top level: register bank feeding the counter, overflow and quota blocks
`timescale 1ns/1ps
`include "pmu_config.svh"

module pmu_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  pmu_pkg::event_vec_t        events_i,
    input  logic                       reg_we_i,
    input  logic [`PMU_ADDR_WIDTH-1:0] reg_addr_i,
    input  pmu_pkg::counter_t          reg_wdata_i,
    output pmu_pkg::counter_t          reg_rdata_o,
    output logic                       intr_overflow_o,
    output logic                       intr_quota_o
);

    // Register bank outputs
    pmu_pkg::pmu_cfg_t       cfg;
    pmu_pkg::cnt_load_t      cnt_load;
    pmu_pkg::event_vec_t     ovf_mask;
    pmu_pkg::event_vec_t     quota_mask;
    pmu_pkg::counter_t       quota_limit;
    // Monitoring block outputs
    pmu_pkg::counter_array_t counts;
    pmu_pkg::event_vec_t     wrap;
    pmu_pkg::event_vec_t     ovf_vect;

    // Software view
    pmu_regbank u_regbank (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .reg_we_i      (reg_we_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .counts_i      (counts),
        .ovf_vect_i    (ovf_vect),
        .reg_rdata_o   (reg_rdata_o),
        .cfg_o         (cfg),
        .cnt_load_o    (cnt_load),
        .ovf_mask_o    (ovf_mask),
        .quota_mask_o  (quota_mask),
        .quota_limit_o (quota_limit)
    );

    pmu_counters u_counters (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .events_i   (events_i),
        .cfg_i      (cfg),
        .cnt_load_i (cnt_load),
        .counts_o   (counts),
        .wrap_o     (wrap)
    );

    // Wrap pulses into the sticky vector
    pmu_overflow u_overflow (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .cfg_i           (cfg),
        .wrap_i          (wrap),
        .mask_i          (ovf_mask),
        .vect_o          (ovf_vect),
        .intr_overflow_o (intr_overflow_o)
    );

    pmu_quota u_quota (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cfg_i        (cfg),
        .counts_i     (counts),
        .mask_i       (quota_mask),
        .limit_i      (quota_limit),
        .intr_quota_o (intr_quota_o)
    );

endmodule

/* test/pmu_tb.sv */
// PMU testbench driving a stimulus table and checking against a cycle-level reference model
`timescale 1ns/1ps
`include "pmu_config.svh"

module pmu_tb;

    // --------------------------------------------------
    // Operations and config words
    // --------------------------------------------------

    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_RUN   = 2'd2;
    localparam logic [1:0] OP_INTR  = 2'd3;

    localparam logic [31:0] CFG_EN       = 32'h1 << `PMU_CFG_EN;
    localparam logic [31:0] CFG_SOFTRST  = 32'h1 << `PMU_CFG_SOFTRST;
    localparam logic [31:0] CFG_OVF_EN   = 32'h1 << `PMU_CFG_OVF_EN;
    localparam logic [31:0] CFG_OVF_RST  = 32'h1 << `PMU_CFG_OVF_SOFTRST;
    localparam logic [31:0] CFG_QUO_RST  = 32'h1 << `PMU_CFG_QUOTA_SOFTRST;
    localparam logic [31:0] ST_ALL_ON    = 32'h1 << `PMU_CFG_SELFTEST_LSB;
    localparam logic [31:0] ST_ALL_OFF   = 32'h2 << `PMU_CFG_SELFTEST_LSB;
    localparam logic [31:0] ST_ONE_ON    = 32'h3 << `PMU_CFG_SELFTEST_LSB;

    // One table step
    // lit marks a literal expected value in exp
    typedef struct packed {
        logic [1:0]  op;
        logic [3:0]  addr;
        logic [31:0] data;
        logic [8:0]  ev;
        logic        rnd;
        logic [15:0] cycles;
        logic        lit;
        logic [31:0] exp;
    } row_t;

    // DUT ports
    logic                       clk_i;
    logic                       rst_n_i;
    pmu_pkg::event_vec_t        events_i;
    logic                       reg_we_i;
    logic [`PMU_ADDR_WIDTH-1:0] reg_addr_i;
    pmu_pkg::counter_t          reg_wdata_i;
    pmu_pkg::counter_t          reg_rdata_o;
    logic                       intr_overflow_o;
    logic                       intr_quota_o;

    // Table and run bookkeeping
    row_t   table_q[$];
    int     total_cycles;
    int     watchdog_ns;
    integer seed;
    logic   table_ready = 1'b0;

    // Reference model state
    logic [31:0] m_cfg;
    logic [8:0]  m_ovf_mask;
    logic [8:0]  m_quota_mask;
    logic [8:0]  m_vect;
    logic [31:0] m_limit;
    logic [31:0] m_sum;
    logic [31:0] m_cnt [0:8];

    pmu_top u_dut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .events_i        (events_i),
        .reg_we_i        (reg_we_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .reg_rdata_o     (reg_rdata_o),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // State after one rising edge with the given inputs
    task automatic model_step(input logic we, input logic [3:0] addr,
                              input logic [31:0] wdata, input logic [8:0] ev);
        logic [8:0]  eff;
        logic [8:0]  wrap;
        logic [31:0] new_sum;
        logic        counting;
        logic        load;
        int          i;
        case (m_cfg[`PMU_CFG_SELFTEST_LSB +: 2])
            2'b00:   eff = ev;
            2'b01:   eff = '1;
            2'b10:   eff = '0;
            default: eff = 9'h001;
        endcase
        counting = m_cfg[`PMU_CFG_EN] && !m_cfg[`PMU_CFG_SOFTRST];
        // Sum and wraps use the values before the edge
        new_sum = '0;
        wrap    = '0;
        for (i = 0; i < 9; i++) begin
            load = we && (addr == i + 1);
            if (m_quota_mask[i])
                new_sum = new_sum + m_cnt[i];
            if (counting && eff[i] && !load && m_cnt[i] == 32'hFFFF_FFFF)
                wrap[i] = 1'b1;
        end
        if (m_cfg[`PMU_CFG_OVF_SOFTRST])
            m_vect = '0;
        else if (m_cfg[`PMU_CFG_OVF_EN])
            m_vect = m_vect | wrap;
        m_sum = m_cfg[`PMU_CFG_QUOTA_SOFTRST] ? 32'h0 : new_sum;
        for (i = 0; i < 9; i++) begin
            load = we && (addr == i + 1);
            if (m_cfg[`PMU_CFG_SOFTRST])
                m_cnt[i] = '0;
            else if (load)
                m_cnt[i] = wdata;
            else if (counting && eff[i])
                m_cnt[i] = m_cnt[i] + 1;
        end
        // Register writes go last and act from the next edge
        if (we) begin
            case (addr)
                `PMU_ADDR_CFG:         m_cfg = wdata;
                `PMU_ADDR_OVF_MASK:    m_ovf_mask = wdata[8:0];
                `PMU_ADDR_QUOTA_MASK:  m_quota_mask = wdata[8:0];
                `PMU_ADDR_QUOTA_LIMIT: m_limit = wdata;
                default: ;
            endcase
        end
    endtask

    // Expected register read for the current model state
    function automatic logic [31:0] model_read(input logic [3:0] addr);
        logic [31:0] val;
        val = '0;
        if (addr >= `PMU_ADDR_CNT_BASE && addr < `PMU_ADDR_CNT_BASE + 9)
            val = m_cnt[addr - `PMU_ADDR_CNT_BASE];
        else if (addr == `PMU_ADDR_CFG)
            val = m_cfg;
        else if (addr == `PMU_ADDR_OVF_MASK)
            val = {23'h0, m_ovf_mask};
        else if (addr == `PMU_ADDR_OVF_VECT)
            val = {23'h0, m_vect};
        else if (addr == `PMU_ADDR_QUOTA_MASK)
            val = {23'h0, m_quota_mask};
        else if (addr == `PMU_ADDR_QUOTA_LIMIT)
            val = m_limit;
        return val;
    endfunction

    // --------------------------------------------------
    // Checking and table building
    // --------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s actual 0x%08h expected 0x%08h", name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic append_row(input logic [1:0] op, input logic [3:0] addr,
                              input logic [31:0] data, input logic [8:0] ev,
                              input logic rnd, input int cycles,
                              input logic lit, input logic [31:0] exp);
        row_t r;
        r = '{op, addr, data, ev, rnd, cycles[15:0], lit, exp};
        table_q.push_back(r);
        total_cycles += cycles;
    endtask

    task automatic queue_write(input logic [3:0] addr, input logic [31:0] data);
        append_row(OP_WRITE, addr, data, '0, 1'b0, 1, 1'b0, '0);
    endtask

    // Read compared with the model only
    task automatic expect_model(input logic [3:0] addr);
        append_row(OP_READ, addr, '0, '0, 1'b0, 1, 1'b0, '0);
    endtask

    task automatic expect_reg(input logic [3:0] addr, input logic [31:0] val);
        append_row(OP_READ, addr, '0, '0, 1'b0, 1, 1'b1, val);
    endtask

    task automatic run_pattern(input logic [8:0] ev, input int n);
        append_row(OP_RUN, '0, '0, ev, 1'b0, n, 1'b0, '0);
    endtask

    task automatic run_random(input int n);
        append_row(OP_RUN, '0, '0, '0, 1'b1, n, 1'b0, '0);
    endtask

    // Bit 0 is overflow and bit 1 is quota
    task automatic expect_intr(input logic [1:0] val);
        append_row(OP_INTR, '0, '0, '0, 1'b0, 1, 1'b1, {30'h0, val});
    endtask

    task automatic build_table();
        int a;
        // Reset state and register readback
        expect_intr(2'b00);
        expect_reg(`PMU_ADDR_CFG, 32'h0);
        queue_write(`PMU_ADDR_CFG, CFG_OVF_EN);
        expect_reg(`PMU_ADDR_CFG, CFG_OVF_EN);
        queue_write(`PMU_ADDR_OVF_MASK, 32'h155);
        expect_reg(`PMU_ADDR_OVF_MASK, 32'h155);
        queue_write(`PMU_ADDR_QUOTA_MASK, 32'h0AA);
        expect_reg(`PMU_ADDR_QUOTA_MASK, 32'h0AA);
        queue_write(`PMU_ADDR_QUOTA_LIMIT, 32'h1234_5678);
        expect_reg(`PMU_ADDR_QUOTA_LIMIT, 32'h1234_5678);
        queue_write(4'd14, 32'hFFFF_FFFF);
        expect_reg(4'd14, 32'h0);
        expect_reg(4'd15, 32'h0);
        queue_write(`PMU_ADDR_OVF_VECT, 32'h1FF);
        expect_reg(`PMU_ADDR_OVF_VECT, 32'h0);
        // Random counting and then hold with enable clear
        queue_write(`PMU_ADDR_CFG, CFG_EN | CFG_OVF_EN);
        run_random(40);
        for (a = 0; a < 9; a++)
            expect_model(`PMU_ADDR_CNT_BASE + a);
        queue_write(`PMU_ADDR_CFG, CFG_OVF_EN);
        run_random(10);
        for (a = 0; a < 9; a++)
            expect_model(`PMU_ADDR_CNT_BASE + a);
        // Self-test overrides
        queue_write(`PMU_ADDR_CFG, CFG_EN | ST_ALL_ON);
        run_pattern(9'h000, 20);
        for (a = 0; a < 9; a++)
            expect_model(`PMU_ADDR_CNT_BASE + a);
        queue_write(`PMU_ADDR_CFG, CFG_EN | ST_ALL_OFF);
        run_pattern(9'h1FF, 20);
        expect_model(`PMU_ADDR_CNT_BASE + 0);
        expect_model(`PMU_ADDR_CNT_BASE + 4);
        queue_write(`PMU_ADDR_CFG, CFG_EN | ST_ONE_ON);
        run_pattern(9'h1FE, 20);
        for (a = 0; a < 3; a++)
            expect_model(`PMU_ADDR_CNT_BASE + a);
        // Overflow on counter 3 while masked and then unmasked
        queue_write(`PMU_ADDR_CFG, CFG_EN | CFG_OVF_EN);
        queue_write(`PMU_ADDR_QUOTA_MASK, 32'h0);
        queue_write(`PMU_ADDR_OVF_MASK, 32'h0);
        queue_write(`PMU_ADDR_CNT_BASE + 3, 32'hFFFF_FFFF);
        run_pattern(9'h008, 1);
        expect_reg(`PMU_ADDR_CNT_BASE + 3, 32'h0);
        expect_reg(`PMU_ADDR_OVF_VECT, 32'h008);
        expect_intr(2'b00);
        queue_write(`PMU_ADDR_OVF_MASK, 32'h008);
        expect_intr(2'b01);
        // Wrap ignored with overflow enable clear
        queue_write(`PMU_ADDR_CFG, CFG_EN);
        queue_write(`PMU_ADDR_CNT_BASE + 6, 32'hFFFF_FFFF);
        run_pattern(9'h040, 1);
        expect_reg(`PMU_ADDR_CNT_BASE + 6, 32'h0);
        expect_reg(`PMU_ADDR_OVF_VECT, 32'h008);
        queue_write(`PMU_ADDR_CFG, CFG_EN | CFG_OVF_RST);
        queue_write(`PMU_ADDR_CFG, CFG_EN);
        expect_reg(`PMU_ADDR_OVF_VECT, 32'h0);
        expect_intr(2'b00);
        // Quota crossing lags the mask change by one cycle
        queue_write(`PMU_ADDR_QUOTA_LIMIT, 32'h1000);
        queue_write(`PMU_ADDR_CNT_BASE + 0, 32'h800);
        queue_write(`PMU_ADDR_CNT_BASE + 2, 32'h900);
        queue_write(`PMU_ADDR_QUOTA_MASK, 32'h005);
        expect_intr(2'b00);
        expect_intr(2'b10);
        queue_write(`PMU_ADDR_QUOTA_MASK, 32'h001);
        expect_intr(2'b10);
        expect_intr(2'b00);
        // Quota soft reset holds the sum at zero
        queue_write(`PMU_ADDR_QUOTA_MASK, 32'h005);
        queue_write(`PMU_ADDR_CFG, CFG_EN | CFG_QUO_RST);
        expect_intr(2'b10);
        expect_intr(2'b00);
        run_pattern(9'h000, 5);
        expect_intr(2'b00);
        queue_write(`PMU_ADDR_CFG, CFG_EN);
        expect_intr(2'b00);
        expect_intr(2'b10);
        // Counter soft reset beats live events
        queue_write(`PMU_ADDR_CFG, CFG_EN | CFG_SOFTRST);
        run_pattern(9'h1FF, 5);
        for (a = 0; a < 9; a++)
            expect_reg(`PMU_ADDR_CNT_BASE + a, 32'h0);
    endtask

    // --------------------------------------------------
    // Row application
    // --------------------------------------------------

    task automatic advance_cycle();
        model_step(reg_we_i, reg_addr_i, reg_wdata_i, events_i);
        @(posedge clk_i);
        #1;
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] rnd_word;
        string       name;
        case (r.op)
            OP_WRITE: begin
                reg_we_i    = 1'b1;
                reg_addr_i  = r.addr;
                reg_wdata_i = r.data;
                events_i    = r.ev;
                advance_cycle();
                reg_we_i    = 1'b0;
            end
            OP_READ: begin
                reg_addr_i = r.addr;
                events_i   = '0;
                #1;
                name = $sformatf("reg_rdata_o at 0x%0h", r.addr);
                check_value(name, reg_rdata_o, model_read(r.addr));
                if (r.lit)
                    check_value(name, reg_rdata_o, r.exp);
                advance_cycle();
            end
            OP_RUN: begin
                for (int n = 0; n < r.cycles; n++) begin
                    rnd_word = $random(seed);
                    events_i = r.rnd ? rnd_word[8:0] : r.ev;
                    advance_cycle();
                end
                events_i = '0;
            end
            default: begin
                events_i = '0;
                #1;
                check_value("intr_overflow_o", {31'h0, intr_overflow_o},
                            {31'h0, |(m_vect & m_ovf_mask)});
                check_value("intr_quota_o", {31'h0, intr_quota_o},
                            {31'h0, m_sum > m_limit});
                check_value("intr_overflow_o", {31'h0, intr_overflow_o}, {31'h0, r.exp[0]});
                check_value("intr_quota_o", {31'h0, intr_quota_o}, {31'h0, r.exp[1]});
                advance_cycle();
            end
        endcase
    endtask

    // Limit of twice the table length plus reset and a margin
    initial begin
        wait (table_ready);
        #(watchdog_ns);
        $display("Timeout: the stimulus table did not complete within %0d ns", watchdog_ns);
        $display("Simulation finished: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rst_n_i      = 1'b0;
        events_i     = '0;
        reg_we_i     = 1'b0;
        reg_addr_i   = '0;
        reg_wdata_i  = '0;
        seed         = 29681;
        total_cycles = 0;
        m_cfg        = '0;
        m_ovf_mask   = '0;
        m_quota_mask = '0;
        m_vect       = '0;
        m_limit      = '0;
        m_sum        = '0;
        for (int i = 0; i < 9; i++)
            m_cnt[i] = '0;
        build_table();
        watchdog_ns = 2 * (total_cycles + 3) * 10 + 200;
        table_ready = 1'b1;
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        foreach (table_q[k])
            apply_row(table_q[k]);
        // Any mismatch has already stopped the run
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* project.f */
+incdir+logic
logic/pmu_pkg.sv
logic/pmu_regbank.sv
logic/pmu_counters.sv
logic/pmu_overflow.sv
logic/pmu_quota.sv
logic/pmu_top.sv
test/pmu_tb.sv
